// ==== sources.f ====
rtl/ctrl_port_pkg.sv
rtl/keypad_matrix.sv
rtl/trackball_feed.sv
rtl/port_mux.sv
rtl/riot_port_pack.sv
rtl/controller_top.sv
tb/ctrl_checker.sv
tb/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the controller testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project directory"
	exit 1
fi

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_top \
	-Mdir obj_dir -o tb_top_sim -f sources.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== tb/tb_top.sv ====
// Testbench top driving the controller input path from a stimulus table
`timescale 1ns/1ps

module tb_top import ctrl_port_pkg::*; ();

	localparam int CLK_NS       = 10;
	localparam int RESET_CYCLES = 8;
	localparam int ROW_BUDGET   = 20;

	localparam logic [PS2_KEY_W-1:0]   NO_KEY   = '0;
	localparam logic [PS2_MOUSE_W-1:0] NO_MOUSE = '0;

	logic                   clk_sys = 1'b0;
	logic                   reset;
	logic [JOY_W-1:0]       joy_a;
	logic [JOY_W-1:0]       joy_b;
	dev_type_t              dev_a;
	dev_type_t              dev_b;
	logic [PS2_KEY_W-1:0]   ps2_key;
	logic [PS2_MOUSE_W-1:0] ps2_mouse;
	logic                   pa_read;
	logic [7:0]             pa_out;
	logic [7:0]             pb_out;
	logic                   tia_en;
	logic                   diff_left;
	logic                   diff_right;
	logic [7:0]             pa_in;
	logic [7:0]             pb_in;
	logic [1:0]             ilatch;
	logic [3:0]             idump;
	int                     errors;
	int                     checks;

	// ==============================
	// Stimulus table with one entry per row
	// ==============================
	dev_type_t        t_dev_a [$];
	dev_type_t        t_dev_b [$];
	logic             t_rand  [$];
	logic [JOY_W-1:0] t_joy_a [$];
	logic [JOY_W-1:0] t_joy_b [$];
	logic [7:0]       t_pa    [$];
	logic [7:0]       t_pb    [$];
	// {tia_en, diff_left, diff_right}
	logic [2:0]       t_con   [$];
	// {valid, press, code}
	logic [10:0]      t_key   [$];
	// {valid, y, x, status}
	logic [24:0]      t_mouse [$];
	logic             t_read  [$];
	int               t_hold  [$];

	always #(CLK_NS / 2) clk_sys = ~clk_sys;

	controller_top dut (.*);

	ctrl_checker u_checker (.*);

	function automatic logic [10:0] key_down(input logic [KEY_CODE_W-1:0] code);
		return {1'b1, 1'b1, code};
	endfunction

	function automatic logic [10:0] key_up(input logic [KEY_CODE_W-1:0] code);
		return {1'b1, 1'b0, code};
	endfunction

	// Status byte carries the sign of each move in bits 4 and 5
	function automatic logic [24:0] mouse_move(input logic [1:0] btn, input logic [7:0] dx,
		input logic [7:0] dy);
		return {1'b1, dy, dx, 2'b00, dy[7], dx[7], 2'b00, btn};
	endfunction

	task automatic add_row(input dev_type_t da, input dev_type_t db, input logic rnd,
		input logic [JOY_W-1:0] ja, input logic [JOY_W-1:0] jb, input logic [7:0] pa,
		input logic [7:0] pb, input logic [2:0] con, input logic [10:0] key,
		input logic [24:0] mouse, input logic rd, input int hold);
		t_dev_a.push_back(da);
		t_dev_b.push_back(db);
		t_rand.push_back(rnd);
		t_joy_a.push_back(ja);
		t_joy_b.push_back(jb);
		t_pa.push_back(pa);
		t_pb.push_back(pb);
		t_con.push_back(con);
		t_key.push_back(key);
		t_mouse.push_back(mouse);
		t_read.push_back(rd);
		t_hold.push_back(hold);
	endtask

	task automatic keypad_row(input logic [7:0] pa, input logic [10:0] key);
		add_row(dev_keypad, dev_keypad, 1'b0, '0, '0, pa, 8'hFF, 3'b100, key, NO_MOUSE,
			1'b0, 4);
	endtask

	task automatic trackball_row(input logic [24:0] mouse, input logic rd, input int hold);
		add_row(dev_trackball, dev_trackball, 1'b0, '0, '0, 8'h00, 8'hFF, 3'b100, NO_KEY,
			mouse, rd, hold);
	endtask

	// Fire1 on port A, fire2 on port B
	task automatic latch_row(input dev_type_t da, input dev_type_t db, input logic [7:0] pb,
		input logic [2:0] con);
		add_row(da, db, 1'b0, 16'h0010, 16'h0020, 8'h00, pb, con, NO_KEY, NO_MOUSE, 1'b0, 3);
	endtask

	task automatic build_table();
		for (int i = 0; i < 6; i++)
			add_row(dev_joystick, dev_joystick, 1'b1, '0, '0, 8'h00, 8'(i * 71), 3'(i),
				NO_KEY, NO_MOUSE, 1'b0, 3);
		// Both layouts, shared columns, a code off the pad
		keypad_row(8'h5A, key_down(SC_1));
		keypad_row(8'hA5, key_down(SC_S));
		keypad_row(8'h3C, key_down(SC_EQUALS));
		keypad_row(8'h96, key_down(SC_3));
		keypad_row(8'h69, key_down(SC_C));
		keypad_row(8'h0F, key_up(SC_Z));
		keypad_row(8'hF0, key_down(9'h029));
		keypad_row(8'hC3, key_up(SC_MINUS));
		keypad_row(8'h5A, key_down(SC_Q));
		keypad_row(8'h99, key_down(SC_X));
		keypad_row(8'h66, key_up(SC_1));
		keypad_row(8'hE7, key_up(SC_8));
		keypad_row(8'h18, key_up(SC_E));
		add_row(dev_keypad, dev_joystick, 1'b1, '0, '0, 8'hA5, 8'hFF, 3'b101, NO_KEY,
			NO_MOUSE, 1'b0, 4);
		// Trackball drained by port A reads
		trackball_row(mouse_move(2'b01, 8'd3, 8'hFD), 1'b0, 2);
		for (int i = 0; i < 5; i++)
			trackball_row(NO_MOUSE, 1'b1, 2);
		trackball_row(mouse_move(2'b00, 8'hFB, 8'd2), 1'b1, 2);
		for (int i = 0; i < 6; i++)
			trackball_row(NO_MOUSE, 1'b1, 3);
		trackball_row(mouse_move(2'b10, 8'hFE, 8'h81), 1'b0, 1);
		for (int i = 0; i < 3; i++)
			trackball_row(NO_MOUSE, 1'b1, 2);
		// Two-button override and empty ports
		latch_row(dev_joystick, dev_joystick, 8'hFF, 3'b000);
		latch_row(dev_joystick, dev_joystick, 8'hFB, 3'b000);
		latch_row(dev_joystick, dev_joystick, 8'hEF, 3'b001);
		latch_row(dev_joystick, dev_joystick, 8'h00, 3'b110);
		latch_row(dev_joystick, dev_joystick, 8'h00, 3'b000);
		latch_row(dev_none, dev_none, 8'hFF, 3'b100);
		latch_row(dev_none, dev_none, 8'h00, 3'b011);
		latch_row(dev_none, dev_joystick, 8'hEB, 3'b000);
	endtask

	// Events and the read strobe go out on the first cycle of a row only
	task automatic apply_row(input int r);
		logic [31:0] rnd_a;
		logic [31:0] rnd_b;
		for (int c = 0; c < t_hold[r]; c++) begin
			@(posedge clk_sys);
			rnd_a = $urandom;
			rnd_b = $urandom;
			dev_a      <= t_dev_a[r];
			dev_b      <= t_dev_b[r];
			joy_a      <= t_rand[r] ? rnd_a[JOY_W-1:0] : t_joy_a[r];
			joy_b      <= t_rand[r] ? rnd_b[JOY_W-1:0] : t_joy_b[r];
			pa_out     <= t_pa[r];
			pb_out     <= t_pb[r];
			tia_en     <= t_con[r][2];
			diff_left  <= t_con[r][1];
			diff_right <= t_con[r][0];
			pa_read    <= (c == 0) && t_read[r];
			if (c == 0 && t_key[r][10])
				ps2_key <= {~ps2_key[KEY_STROBE_BIT], t_key[r][9:0]};
			if (c == 0 && t_mouse[r][24])
				ps2_mouse <= {~ps2_mouse[MOUSE_STROBE_BIT], t_mouse[r][23:0]};
		end
	endtask

	initial begin
		void'($urandom(12));
		reset      <= 1'b1;
		joy_a      <= '0;
		joy_b      <= '0;
		dev_a      <= dev_none;
		dev_b      <= dev_none;
		ps2_key    <= '0;
		ps2_mouse  <= '0;
		pa_read    <= 1'b0;
		pa_out     <= 8'h00;
		pb_out     <= 8'hFF;
		tia_en     <= 1'b1;
		diff_left  <= 1'b0;
		diff_right <= 1'b0;
		build_table();
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset <= 1'b0;
		for (int r = 0; r < t_hold.size(); r++)
			apply_row(r);
		@(posedge clk_sys);
		pa_read <= 1'b0;
		// Let the pipeline empty
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		$display("closing: %0d checks, %0d errors", checks, errors);
		if (errors == 0 && checks > 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// Watchdog
	initial begin
		int limit;
		#1;
		limit = (t_hold.size() * ROW_BUDGET + RESET_CYCLES) * CLK_NS;
		#(limit);
		$display("timeout: the run did not finish within %0d ns", limit);
		$display("test failed");
		$finish;
	end

endmodule

// ==== tb/ctrl_checker.sv ====
// Reference model and scoreboard that predicts and compares the controller outputs
`timescale 1ns/1ps

module ctrl_checker import ctrl_port_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [JOY_W-1:0]       joy_a,
	input  logic [JOY_W-1:0]       joy_b,
	input  dev_type_t              dev_a,
	input  dev_type_t              dev_b,
	input  logic [PS2_KEY_W-1:0]   ps2_key,
	input  logic [PS2_MOUSE_W-1:0] ps2_mouse,
	input  logic                   pa_read,
	input  logic [7:0]             pa_out,
	input  logic [7:0]             pb_out,
	input  logic                   tia_en,
	input  logic                   diff_left,
	input  logic                   diff_right,
	input  logic [7:0]             pa_in,
	input  logic [7:0]             pb_in,
	input  logic [1:0]             ilatch,
	input  logic [3:0]             idump,
	output int                     errors,
	output int                     checks
);

	// Output view packed as {pa_in, pb_in, ilatch, idump}
	localparam logic [21:0] RESET_VIEW = {8'hFF, 8'hFF, 2'b11, 4'b0000};

	logic [NUM_KEYS-1:0] held;
	logic                key_last;
	logic                mouse_last;
	int                  x_left;
	int                  y_left;
	logic                x_flip;
	logic                y_flip;
	logic                x_dir;
	logic                y_dir;
	logic                ball_btn;
	logic [3:0]          ball_nib;
	logic [21:0]         exp1;
	logic [21:0]         exp2;
	logic                primed = 1'b0;
	int                  err_count = 0;
	int                  check_count = 0;

	assign errors = err_count;
	assign checks = check_count;

	// Pad slot of a scan code, -1 when the key is not on the pad
	function automatic int key_slot(input logic [KEY_CODE_W-1:0] code);
		case (code)
			SC_1:             return 0;
			SC_2:             return 1;
			SC_3:             return 2;
			SC_4, SC_Q:       return 3;
			SC_5, SC_W:       return 4;
			SC_6, SC_E:       return 5;
			SC_7, SC_A:       return 6;
			SC_8, SC_S:       return 7;
			SC_9, SC_D:       return 8;
			SC_EQUALS, SC_Z:  return 9;
			SC_0, SC_X:       return 10;
			SC_MINUS, SC_C:   return 11;
			default:          return -1;
		endcase
	endfunction

	// One port as {nibble, latch, dump}
	function automatic logic [6:0] port_view(
		input dev_type_t           dev,
		input logic [JOY_W-1:0]    joy,
		input logic [3:0]          drive,
		input logic [NUM_KEYS-1:0] keys,
		input logic [3:0]          nib,
		input logic                btn
	);
		logic [2:0] col;
		logic       fire;
		col  = 3'b111;
		fire = joy[JOY_FIRE1] | joy[JOY_FIRE2];
		// Walk rows upward so the highest held row decides
		for (int r = 0; r < KP_ROWS; r++) begin
			for (int c = 0; c < KP_COLS; c++) begin
				if (keys[4'(r * KP_COLS + c)])
					col[2'(c)] = drive[2'(r)];
			end
		end
		case (dev)
			dev_joystick:
				return {~joy[JOY_RIGHT], ~joy[JOY_LEFT], ~joy[JOY_DOWN], ~joy[JOY_UP],
					~fire, joy[JOY_FIRE1], joy[JOY_FIRE2]};
			dev_trackball:
				return {nib, ~btn, 2'b00};
			dev_keypad:
				return {drive, col[2], col[1], col[0]};
			default:
				return {4'b1111, 1'b1, 2'b00};
		endcase
	endfunction

	function automatic logic [21:0] predict();
		logic [6:0] p0;
		logic [6:0] p1;
		logic [1:0] latch;
		logic [7:0] pb;
		p0 = port_view(dev_a, joy_a, pa_out[7:4], held, ball_nib, ball_btn);
		p1 = port_view(dev_b, joy_b, pa_out[3:0], held, ball_nib, ball_btn);
		// Two-button mode pulls the latch high
		latch[0] = p0[2] | (!pb_out[2] && !tia_en);
		latch[1] = p1[2] | (!pb_out[4] && !tia_en);
		pb[7] = ~diff_right;
		pb[6] = ~diff_left;
		pb[5] = pb_out[5];
		pb[4] = pb_out[4];
		pb[3] = ~(joy_a[JOY_PAUSE] | joy_b[JOY_PAUSE]);
		pb[2] = pb_out[2];
		pb[1] = ~(joy_a[JOY_SELECT] | joy_b[JOY_SELECT]);
		pb[0] = ~(joy_a[JOY_START] | joy_b[JOY_START]);
		return {p0[6:3], p1[6:3], pb, latch, p1[1:0], p0[1:0]};
	endfunction

	task automatic check_field(input string name, input logic [7:0] got, input logic [7:0] want);
		if (got !== want) begin
			err_count++;
			$display("[ERROR] t=%0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	// ==============================
	// Model, two output stages deep
	// ==============================
	always @(posedge clk_sys) begin
		int         slot;
		logic [7:0] dx;
		logic [7:0] dy;
		dx = ps2_mouse[MOUSE_X_LSB +: 8];
		dy = ps2_mouse[MOUSE_Y_LSB +: 8];
		if (reset) begin
			held       <= '0;
			key_last   <= 1'b0;
			mouse_last <= 1'b0;
			x_left     <= 0;
			y_left     <= 0;
			x_flip     <= 1'b0;
			y_flip     <= 1'b0;
			x_dir      <= 1'b0;
			y_dir      <= 1'b0;
			ball_btn   <= 1'b0;
			ball_nib   <= 4'b0000;
			exp1       <= RESET_VIEW;
			exp2       <= RESET_VIEW;
			primed     <= 1'b1;
		end else begin
			exp1 <= predict();
			exp2 <= exp1;

			key_last <= ps2_key[KEY_STROBE_BIT];
			if (ps2_key[KEY_STROBE_BIT] != key_last) begin
				slot = key_slot(ps2_key[KEY_CODE_W-1:0]);
				if (slot >= 0)
					held[slot[3:0]] <= ps2_key[KEY_PRESS_BIT];
			end

			// Port A read steps the ball, nibble shows the toggles before the step
			mouse_last <= ps2_mouse[MOUSE_STROBE_BIT];
			if (pa_read) begin
				ball_nib <= {y_flip, y_dir, x_flip, x_dir};
				if (x_left > 0) begin
					x_left <= x_left - 1;
					x_flip <= !x_flip;
				end
				if (y_left > 0) begin
					y_left <= y_left - 1;
					y_flip <= !y_flip;
				end
			end
			if (ps2_mouse[MOUSE_STROBE_BIT] != mouse_last) begin
				x_left   <= ps2_mouse[MOUSE_X_SIGN] ? 255 - int'(dx) : int'(dx);
				y_left   <= ps2_mouse[MOUSE_Y_SIGN] ? 255 - int'(dy) : int'(dy);
				x_dir    <= !ps2_mouse[MOUSE_X_SIGN];
				y_dir    <= ps2_mouse[MOUSE_Y_SIGN];
				ball_btn <= ps2_mouse[MOUSE_BTN_L] | ps2_mouse[MOUSE_BTN_R];
			end
		end
	end

	// Compare mid-cycle, away from the clock edge
	always @(negedge clk_sys) begin
		if (primed) begin
			check_count++;
			check_field("pa_in", pa_in, exp2[21:14]);
			check_field("pb_in", pb_in, exp2[13:6]);
			check_field("ilatch", {6'b0, ilatch}, {6'b0, exp2[5:4]});
			check_field("idump", {4'b0, idump}, {4'b0, exp2[3:0]});
		end
	end

endmodule

// ==== rtl/controller_top.sv ====
// Controller input top level joining keypad, trackball, port muxes and RIOT packer
`timescale 1ns/1ps

module controller_top import ctrl_port_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [JOY_W-1:0]       joy_a,
	input  logic [JOY_W-1:0]       joy_b,
	input  dev_type_t              dev_a,
	input  dev_type_t              dev_b,
	input  logic [PS2_KEY_W-1:0]   ps2_key,
	input  logic [PS2_MOUSE_W-1:0] ps2_mouse,
	input  logic                   pa_read,
	input  logic [7:0]             pa_out,
	input  logic [7:0]             pb_out,
	input  logic                   tia_en,
	input  logic                   diff_left,
	input  logic                   diff_right,
	output logic [7:0]             pa_in,
	output logic [7:0]             pb_in,
	output logic [1:0]             ilatch,
	output logic [3:0]             idump
);

	logic [NUM_KEYS-1:0] key_held;
	logic [3:0]          tb_nibble;
	logic                tb_button;

	dev_type_t           port_dev    [NUM_PORTS];
	logic [JOY_W-1:0]    port_joy    [NUM_PORTS];
	logic [3:0]          port_nibble [NUM_PORTS];
	logic                port_latch  [NUM_PORTS];
	logic [1:0]          port_dump   [NUM_PORTS];

	assign port_dev[0] = dev_a;
	assign port_dev[1] = dev_b;
	assign port_joy[0] = joy_a;
	assign port_joy[1] = joy_b;

	keypad_matrix u_keypad (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ps2_key  (ps2_key),
		.key_held (key_held)
	);

	trackball_feed u_trackball (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ps2_mouse (ps2_mouse),
		.pa_read   (pa_read),
		.tb_nibble (tb_nibble),
		.tb_button (tb_button)
	);

	// Port 0 drives pa_out[7:4], port 1 pa_out[3:0]
	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
		port_mux u_mux (
			.clk_sys    (clk_sys),
			.reset      (reset),
			.dev_type   (port_dev[i]),
			.joy        (port_joy[i]),
			.kp_drive   (pa_out[(NUM_PORTS-1-i)*4 +: 4]),
			.key_held   (key_held),
			.tb_nibble  (tb_nibble),
			.tb_button  (tb_button),
			.nibble     (port_nibble[i]),
			.fire_latch (port_latch[i]),
			.dump       (port_dump[i])
		);
	end

	riot_port_pack u_pack (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.nibble_0   (port_nibble[0]),
		.nibble_1   (port_nibble[1]),
		.latch_0    (port_latch[0]),
		.latch_1    (port_latch[1]),
		.dump_0     (port_dump[0]),
		.dump_1     (port_dump[1]),
		.joy_a      (joy_a),
		.joy_b      (joy_b),
		.pb_out     (pb_out),
		.tia_en     (tia_en),
		.diff_left  (diff_left),
		.diff_right (diff_right),
		.pa_in      (pa_in),
		.pb_in      (pb_in),
		.ilatch     (ilatch),
		.idump      (idump)
	);

endmodule

// ==== rtl/riot_port_pack.sv ====
// RIOT and TIA input packer with console switches and two-button latch override
`timescale 1ns/1ps

module riot_port_pack import ctrl_port_pkg::*; (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic [3:0]       nibble_0,
	input  logic [3:0]       nibble_1,
	input  logic             latch_0,
	input  logic             latch_1,
	input  logic [1:0]       dump_0,
	input  logic [1:0]       dump_1,
	input  logic [JOY_W-1:0] joy_a,
	input  logic [JOY_W-1:0] joy_b,
	input  logic [7:0]       pb_out,
	input  logic             tia_en,
	input  logic             diff_left,
	input  logic             diff_right,
	output logic [7:0]       pa_in,
	output logic [7:0]       pb_in,
	output logic [1:0]       ilatch,
	output logic [3:0]       idump
);

	// Console side, delayed to line up with the port muxes
	logic [2:0] pb_echo_q;
	logic       tia_en_q;
	logic       diff_left_q;
	logic       diff_right_q;
	logic       pause_q;
	logic       select_q;
	logic       start_q;
	logic       two_btn_a;
	logic       two_btn_b;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pb_echo_q    <= 3'b111;
			tia_en_q     <= 1'b0;
			diff_left_q  <= 1'b0;
			diff_right_q <= 1'b0;
			pause_q      <= 1'b0;
			select_q     <= 1'b0;
			start_q      <= 1'b0;
		end else begin
			pb_echo_q    <= {pb_out[5], pb_out[4], pb_out[2]};
			tia_en_q     <= tia_en;
			diff_left_q  <= diff_left;
			diff_right_q <= diff_right;
			// Either stick may press the console keys
			pause_q      <= joy_a[JOY_PAUSE] | joy_b[JOY_PAUSE];
			select_q     <= joy_a[JOY_SELECT] | joy_b[JOY_SELECT];
			start_q      <= joy_a[JOY_START] | joy_b[JOY_START];
		end
	end

	// Two-button mode holds pin 6 high
	assign two_btn_a = ~pb_echo_q[0] & ~tia_en_q;
	assign two_btn_b = ~pb_echo_q[1] & ~tia_en_q;

	// ==============================
	// Output register
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pa_in  <= 8'hFF;
			pb_in  <= 8'hFF;
			ilatch <= 2'b11;
			idump  <= 4'b0000;
		end else begin
			pa_in  <= {nibble_0, nibble_1};
			ilatch <= {latch_1 | two_btn_b, latch_0 | two_btn_a};
			idump  <= {dump_1, dump_0};
			pb_in  <= {~diff_right_q, ~diff_left_q, pb_echo_q[2], pb_echo_q[1],
				~pause_q, pb_echo_q[0], ~select_q, ~start_q};
		end
	end

endmodule

// ==== rtl/port_mux.sv ====
// Port multiplexer that picks one port's nibble, fire latch and dump pair by device
`timescale 1ns/1ps

module port_mux import ctrl_port_pkg::*; (
	input  logic                clk_sys,
	input  logic                reset,
	input  dev_type_t           dev_type,
	input  logic [JOY_W-1:0]    joy,
	input  logic [3:0]          kp_drive,
	input  logic [NUM_KEYS-1:0] key_held,
	input  logic [3:0]          tb_nibble,
	input  logic                tb_button,
	output logic [3:0]          nibble,
	output logic                fire_latch,
	output logic [1:0]          dump
);

	logic [KP_COLS-1:0] kp_col;
	logic [3:0]         nibble_d;
	logic               latch_d;
	logic [1:0]         dump_d;
	logic               fire_any;

	assign fire_any = joy[JOY_FIRE1] | joy[JOY_FIRE2];

	// ==============================
	// Keypad columns
	// ==============================
	// Pulled up until a held key connects the column to its row drive.
	// Later rows override earlier ones
	always_comb begin
		kp_col = '1;
		for (int row = 0; row < KP_ROWS; row++) begin
			for (int col = 0; col < KP_COLS; col++) begin
				if (key_held[row*KP_COLS + col])
					kp_col[col] = kp_drive[row];
			end
		end
	end

	// ==============================
	// Device select
	// ==============================
	always_comb begin
		nibble_d = 4'b1111;
		latch_d  = 1'b1;
		dump_d   = 2'b00;
		case (dev_type)
			dev_joystick: begin
				// Active low directions, R L D U
				nibble_d = ~{joy[JOY_RIGHT], joy[JOY_LEFT], joy[JOY_DOWN], joy[JOY_UP]};
				latch_d  = ~fire_any;
				dump_d   = {joy[JOY_FIRE1], joy[JOY_FIRE2]};
			end
			dev_trackball: begin
				nibble_d = tb_nibble;
				latch_d  = ~tb_button;
			end
			dev_keypad: begin
				// Rows are driven by the console and read back as is
				nibble_d = kp_drive;
				latch_d  = kp_col[2];
				dump_d   = kp_col[1:0];
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nibble     <= 4'b1111;
			fire_latch <= 1'b1;
			dump       <= 2'b00;
		end else begin
			nibble     <= nibble_d;
			fire_latch <= latch_d;
			dump       <= dump_d;
		end
	end

	dev_type_known: assert property (
		@(posedge clk_sys) disable iff (reset) !$isunknown(dev_type)
	) else $error("port device type is unknown");

endmodule

// ==== rtl/trackball_feed.sv ====
// Trackball feed that turns mouse packets into direction and toggle pulses per port read
`timescale 1ns/1ps

module trackball_feed import ctrl_port_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [PS2_MOUSE_W-1:0] ps2_mouse,
	input  logic                   pa_read,
	output logic [3:0]             tb_nibble,
	output logic                   tb_button
);

	logic                last_strobe;
	logic                mouse_pkt;
	logic [TB_CNT_W-1:0] x_byte;
	logic [TB_CNT_W-1:0] y_byte;
	logic [TB_CNT_W-1:0] x_cnt;
	logic [TB_CNT_W-1:0] y_cnt;
	logic                xtog;
	logic                ytog;
	logic                dir_x;
	logic                dir_y;

	assign mouse_pkt = ps2_mouse[MOUSE_STROBE_BIT] != last_strobe;
	assign x_byte    = ps2_mouse[MOUSE_X_LSB +: TB_CNT_W];
	assign y_byte    = ps2_mouse[MOUSE_Y_LSB +: TB_CNT_W];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			last_strobe <= 1'b0;
			x_cnt       <= '0;
			y_cnt       <= '0;
			xtog        <= 1'b0;
			ytog        <= 1'b0;
			dir_x       <= 1'b0;
			dir_y       <= 1'b0;
			tb_nibble   <= '0;
			tb_button   <= 1'b0;
		end else begin
			last_strobe <= ps2_mouse[MOUSE_STROBE_BIT];

			// One step of movement per port A read
			if (pa_read) begin
				if (x_cnt != '0) begin
					x_cnt <= x_cnt - 1'b1;
					xtog  <= ~xtog;
				end
				if (y_cnt != '0) begin
					y_cnt <= y_cnt - 1'b1;
					ytog  <= ~ytog;
				end
				tb_nibble <= {ytog, dir_y, xtog, dir_x};
			end

			// A fresh packet takes over the counts
			if (mouse_pkt) begin
				x_cnt     <= ps2_mouse[MOUSE_X_SIGN] ? ~x_byte : x_byte;
				y_cnt     <= ps2_mouse[MOUSE_Y_SIGN] ? ~y_byte : y_byte;
				dir_x     <= ~ps2_mouse[MOUSE_X_SIGN];  // x runs opposite on this ball
				dir_y     <= ps2_mouse[MOUSE_Y_SIGN];
				tb_button <= ps2_mouse[MOUSE_BTN_L] | ps2_mouse[MOUSE_BTN_R];
			end
		end
	end

	// Counts only drain between packets
	count_drains_only: assert property (
		@(posedge clk_sys) disable iff (reset)
		!mouse_pkt |=> (x_cnt <= $past(x_cnt)) && (y_cnt <= $past(y_cnt))
	) else $error("trackball count rose without a mouse packet");

endmodule

// ==== rtl/keypad_matrix.sv ====
// Keypad matrix that tracks twelve held keys from PS/2 key events
`timescale 1ns/1ps

module keypad_matrix import ctrl_port_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic [PS2_KEY_W-1:0] ps2_key,
	output logic [NUM_KEYS-1:0]  key_held
);

	logic                 last_strobe;
	logic                 key_event;
	logic                 key_known;
	logic [KEY_IDX_W-1:0] key_idx;

	// New event whenever the strobe bit toggles
	assign key_event = ps2_key[KEY_STROBE_BIT] != last_strobe;

	// ==============================
	// Scan code decode
	// ==============================
	always_comb begin
		key_known = 1'b1;
		key_idx   = '0;
		case (ps2_key[KEY_CODE_W-1:0])
			SC_1:      key_idx = KEY_IDX_1;
			SC_2:      key_idx = KEY_IDX_2;
			SC_3:      key_idx = KEY_IDX_3;
			// Number row
			SC_4:      key_idx = KEY_IDX_4;
			SC_5:      key_idx = KEY_IDX_5;
			SC_6:      key_idx = KEY_IDX_6;
			SC_7:      key_idx = KEY_IDX_7;
			SC_8:      key_idx = KEY_IDX_8;
			SC_9:      key_idx = KEY_IDX_9;
			SC_0:      key_idx = KEY_IDX_0;
			SC_MINUS:  key_idx = KEY_IDX_HASH;
			SC_EQUALS: key_idx = KEY_IDX_STAR;
			// Letter block, laid out like the pad
			SC_Q:      key_idx = KEY_IDX_4;
			SC_W:      key_idx = KEY_IDX_5;
			SC_E:      key_idx = KEY_IDX_6;
			SC_A:      key_idx = KEY_IDX_7;
			SC_S:      key_idx = KEY_IDX_8;
			SC_D:      key_idx = KEY_IDX_9;
			SC_Z:      key_idx = KEY_IDX_STAR;
			SC_X:      key_idx = KEY_IDX_0;
			SC_C:      key_idx = KEY_IDX_HASH;
			default:   key_known = 1'b0;
		endcase
	end

	// ==============================
	// Held key state
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			last_strobe <= 1'b0;
			key_held    <= '0;
		end else begin
			last_strobe <= ps2_key[KEY_STROBE_BIT];
			// Press sets, release clears
			if (key_event && key_known)
				key_held[key_idx] <= ps2_key[KEY_PRESS_BIT];
		end
	end

	// Nothing stays held across a reset
	held_clear_after_reset: assert property (
		@(posedge clk_sys) reset |=> key_held == '0
	) else $error("keypad keys still held after reset");

endmodule

// ==== rtl/ctrl_port_pkg.sv ====
// Controller port package with device types, field positions and keypad scan codes
package ctrl_port_pkg;

	// Device attached to a controller port
	typedef enum logic [1:0] {
		dev_none      = 2'd0,
		dev_joystick  = 2'd1,
		dev_trackball = 2'd2,
		dev_keypad    = 2'd3
	} dev_type_t;

	localparam int NUM_PORTS = 2;

	// ==============================
	// Host joystick word
	// ==============================
	localparam int JOY_W      = 16;
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE1  = 4;
	localparam int JOY_FIRE2  = 5;
	localparam int JOY_PAUSE  = 6;
	localparam int JOY_SELECT = 7;
	localparam int JOY_START  = 8;

	// ==============================
	// PS/2 key and mouse words
	// ==============================
	localparam int PS2_KEY_W      = 11;
	localparam int KEY_STROBE_BIT = 10;
	localparam int KEY_PRESS_BIT  = 9;
	localparam int KEY_CODE_W     = 9;

	localparam int PS2_MOUSE_W      = 25;
	localparam int MOUSE_STROBE_BIT = 24;
	localparam int MOUSE_BTN_L      = 0;
	localparam int MOUSE_BTN_R      = 1;
	localparam int MOUSE_X_SIGN     = 4;
	localparam int MOUSE_Y_SIGN     = 5;
	localparam int MOUSE_X_LSB      = 8;
	localparam int MOUSE_Y_LSB      = 16;
	localparam int TB_CNT_W         = 8;

	// ==============================
	// Keypad matrix
	// ==============================
	localparam int NUM_KEYS  = 12;
	localparam int KP_ROWS   = 4;
	localparam int KP_COLS   = 3;
	localparam int KEY_IDX_W = 4;

	// Index is row * 3 + column
	localparam logic [KEY_IDX_W-1:0] KEY_IDX_1    = 4'd0;
	localparam logic [KEY_IDX_W-1:0] KEY_IDX_2    = 4'd1;
	localparam logic [KEY_IDX_W-1:0] KEY_IDX_3    = 4'd2;
	localparam logic [KEY_IDX_W-1:0] KEY_IDX_4    = 4'd3;
	localparam logic [KEY_IDX_W-1:0] KEY_IDX_5    = 4'd4;
	localparam logic [KEY_IDX_W-1:0] KEY_IDX_6    = 4'd5;
	localparam logic [KEY_IDX_W-1:0] KEY_IDX_7    = 4'd6;
	localparam logic [KEY_IDX_W-1:0] KEY_IDX_8    = 4'd7;
	localparam logic [KEY_IDX_W-1:0] KEY_IDX_9    = 4'd8;
	localparam logic [KEY_IDX_W-1:0] KEY_IDX_STAR = 4'd9;
	localparam logic [KEY_IDX_W-1:0] KEY_IDX_0    = 4'd10;
	localparam logic [KEY_IDX_W-1:0] KEY_IDX_HASH = 4'd11;

	// Number row layout
	localparam logic [KEY_CODE_W-1:0] SC_1      = 9'h016;
	localparam logic [KEY_CODE_W-1:0] SC_2      = 9'h01E;
	localparam logic [KEY_CODE_W-1:0] SC_3      = 9'h026;
	localparam logic [KEY_CODE_W-1:0] SC_4      = 9'h025;
	localparam logic [KEY_CODE_W-1:0] SC_5      = 9'h02E;
	localparam logic [KEY_CODE_W-1:0] SC_6      = 9'h036;
	localparam logic [KEY_CODE_W-1:0] SC_7      = 9'h03D;
	localparam logic [KEY_CODE_W-1:0] SC_8      = 9'h03E;
	localparam logic [KEY_CODE_W-1:0] SC_9      = 9'h046;
	localparam logic [KEY_CODE_W-1:0] SC_0      = 9'h045;
	localparam logic [KEY_CODE_W-1:0] SC_MINUS  = 9'h04E;
	localparam logic [KEY_CODE_W-1:0] SC_EQUALS = 9'h055;

	// Letter block layout
	localparam logic [KEY_CODE_W-1:0] SC_Q = 9'h015;
	localparam logic [KEY_CODE_W-1:0] SC_W = 9'h01D;
	localparam logic [KEY_CODE_W-1:0] SC_E = 9'h024;
	localparam logic [KEY_CODE_W-1:0] SC_A = 9'h01C;
	localparam logic [KEY_CODE_W-1:0] SC_S = 9'h01B;
	localparam logic [KEY_CODE_W-1:0] SC_D = 9'h023;
	localparam logic [KEY_CODE_W-1:0] SC_Z = 9'h01A;
	localparam logic [KEY_CODE_W-1:0] SC_X = 9'h022;
	localparam logic [KEY_CODE_W-1:0] SC_C = 9'h021;

endpackage
